// File: nabp_apb_regs.sv
`timescale 1ns/100ps

module nabp_apb_regs
#(
    parameter int ANGLE_W = 8
)
(
    input  logic               clk,
    input  logic               reset_n,
    // apb slave
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [3:0]         paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    // status from swap control
    input  logic               busy,
    input  logic               done,
    input  logic [ANGLE_W:0]   lines_done,
    // run configuration
    output logic               run_start,
    output logic [ANGLE_W-1:0] run_angle_start,
    output logic [ANGLE_W:0]   run_angle_count
);

logic        wr_en;
logic [31:0] status_word;

// writes land on the access cycle edge
assign wr_en = psel && penable && pwrite;

always_ff @(posedge clk)
begin
    if (!reset_n)
    begin
        run_start       <= 1'b0;
        run_angle_start <= '0;
        run_angle_count <= '0;
    end
    else
    begin
        run_start <= 1'b0;
        if (wr_en)
        begin
            case (paddr)
                nabp_ctrl_pkg::REG_CTRL:
                    // ignored while a run is in progress
                    run_start <= pwdata[nabp_ctrl_pkg::CTRL_START_BIT] && !busy;
                nabp_ctrl_pkg::REG_ANGLE_START:
                    run_angle_start <= pwdata[ANGLE_W-1:0];
                nabp_ctrl_pkg::REG_ANGLE_COUNT:
                    run_angle_count <= pwdata[ANGLE_W:0];
                default:
                    ;
            endcase
        end
    end
end

// status word layout
always_comb
begin
    status_word = '0;
    status_word[nabp_ctrl_pkg::STATUS_BUSY_BIT] = busy;
    status_word[nabp_ctrl_pkg::STATUS_DONE_BIT] = done;
    status_word[nabp_ctrl_pkg::STATUS_LINES_LSB +: ANGLE_W + 1] = lines_done;
end

// read mux, ctrl reads as zero
always_comb
begin
    prdata = '0;
    if (psel && !pwrite)
    begin
        case (paddr)
            nabp_ctrl_pkg::REG_ANGLE_START:
                prdata[ANGLE_W-1:0] = run_angle_start;
            nabp_ctrl_pkg::REG_ANGLE_COUNT:
                prdata[ANGLE_W:0] = run_angle_count;
            nabp_ctrl_pkg::REG_STATUS:
                prdata = status_word;
            default:
                prdata = '0;
        endcase
    end
end

// a start never reaches a busy swap control
a_start_not_busy: assert property (
    @(posedge clk) disable iff (!reset_n)
    run_start |-> !busy
);

endmodule

// File: nabp_ctrl_pkg.sv
package nabp_ctrl_pkg;

    // fill/shift sequencing states
    typedef enum logic [2:0] {
        init_s       = 3'd0,
        setup_s      = 3'd1,
        fill_s       = 3'd2,
        fill_done_s  = 3'd3,
        shift_s      = 3'd4,
        shift_done_s = 3'd5
    } state_control_e;

    // apb byte offsets
    parameter logic [3:0] REG_CTRL        = 4'h0;
    parameter logic [3:0] REG_ANGLE_START = 4'h4;
    parameter logic [3:0] REG_ANGLE_COUNT = 4'h8;
    parameter logic [3:0] REG_STATUS      = 4'hC;

    // ctrl register fields
    parameter int CTRL_START_BIT = 0;

    // status register fields
    parameter int STATUS_BUSY_BIT  = 0;
    parameter int STATUS_DONE_BIT  = 1;
    parameter int STATUS_LINES_LSB = 8;

endpackage

// File: nabp_geom_pkg.sv
package nabp_geom_pkg;

    // angle word width, angles wrap modulo 2**ANGLE_W
    parameter int ANGLE_W_DEF = 8;

    // projection sample width
    parameter int DATA_W_DEF = 16;

    // samples in one projection line
    parameter int LINE_LEN_DEF = 16;

endpackage

// File: nabp_shifter.sv
`timescale 1ns/100ps

module nabp_shifter
#(
    parameter int DATA_W   = 16,
    parameter int LINE_LEN = 16
)
(
    input  logic              clk,
    input  logic              reset_n,
    // state control
    input  logic              sh_fill_kick,
    input  logic              sh_shift_kick,
    output logic              sh_fill_done,
    output logic              sh_shift_done,
    // sample stream in
    input  logic [DATA_W-1:0] samp_data,
    input  logic              samp_valid,
    output logic              samp_ready,
    // line stream out
    output logic [DATA_W-1:0] line_data,
    output logic              line_valid,
    output logic              line_last,
    input  logic              line_ready
);

localparam int IDX_W = (LINE_LEN > 1) ? $clog2(LINE_LEN) : 1;
localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(LINE_LEN - 1);

localparam logic [1:0] MODE_IDLE  = 2'd0;
localparam logic [1:0] MODE_FILL  = 2'd1;
localparam logic [1:0] MODE_SHIFT = 2'd2;

logic [1:0]        mode;
logic [DATA_W-1:0] line_buf [LINE_LEN];
logic [IDX_W-1:0]  wr_idx;
logic [IDX_W-1:0]  rd_idx;
logic [IDX_W-1:0]  rd_next;
logic              samp_fire;
logic              line_fire;

assign samp_ready = (mode == MODE_FILL);
assign samp_fire  = samp_valid && samp_ready;
assign line_fire  = line_valid && line_ready;
assign rd_next    = rd_idx + 1'b1;

// line buffer and output data path
always_ff @(posedge clk)
begin
    if (samp_fire)
        line_buf[wr_idx] <= samp_data;
    if (sh_shift_kick)
        line_data <= line_buf[0];
    else if (line_fire && !line_last)
        line_data <= line_buf[rd_next];
end

always_ff @(posedge clk)
begin
    if (!reset_n)
    begin
        mode          <= MODE_IDLE;
        wr_idx        <= '0;
        rd_idx        <= '0;
        line_valid    <= 1'b0;
        line_last     <= 1'b0;
        sh_fill_done  <= 1'b0;
        sh_shift_done <= 1'b0;
    end
    else
    begin
        sh_fill_done  <= 1'b0;
        sh_shift_done <= 1'b0;
        case (mode)
            MODE_IDLE:
                if (sh_fill_kick)
                begin
                    mode   <= MODE_FILL;
                    wr_idx <= '0;
                end
                else if (sh_shift_kick)
                begin
                    mode       <= MODE_SHIFT;
                    rd_idx     <= '0;
                    line_valid <= 1'b1;
                    line_last  <= (LAST_IDX == '0);
                end
            MODE_FILL:
                if (samp_fire)
                begin
                    wr_idx <= wr_idx + 1'b1;
                    // line full, stop accepting
                    if (wr_idx == LAST_IDX)
                    begin
                        mode         <= MODE_IDLE;
                        sh_fill_done <= 1'b1;
                    end
                end
            MODE_SHIFT:
                if (line_fire)
                begin
                    if (line_last)
                    begin
                        mode          <= MODE_IDLE;
                        line_valid    <= 1'b0;
                        line_last     <= 1'b0;
                        sh_shift_done <= 1'b1;
                    end
                    else
                    begin
                        rd_idx    <= rd_next;
                        line_last <= (rd_next == LAST_IDX);
                    end
                end
            default:
                mode <= MODE_IDLE;
        endcase
    end
end

// kicks from state control only land in idle
a_kick_in_idle: assert property (
    @(posedge clk) disable iff (!reset_n)
    (sh_fill_kick || sh_shift_kick) |-> (mode == MODE_IDLE)
);

endmodule

// File: nabp_state_control.sv
`timescale 1ns/100ps

module nabp_state_control
#(
    parameter int ANGLE_W = 8
)
(
    input  logic               clk,
    input  logic               reset_n,
    // swap control
    input  logic [ANGLE_W-1:0] sw_angle,
    input  logic               sw_angle_valid,
    input  logic               sw_swap,
    // angle of the line in flight
    output logic [ANGLE_W-1:0] angle,
    output logic               sw_swap_ready,
    output logic               sw_next_angle,
    // shifter
    input  logic               sh_fill_done,
    input  logic               sh_shift_done,
    output logic               sh_fill_kick,
    output logic               sh_shift_kick
);

nabp_ctrl_pkg::state_control_e state;
nabp_ctrl_pkg::state_control_e next_state;

always_ff @(posedge clk)
begin
    if (!reset_n)
        state <= nabp_ctrl_pkg::init_s;
    else
        state <= next_state;
end

// angle latched while waiting in setup
always_ff @(posedge clk)
begin
    if (state == nabp_ctrl_pkg::setup_s)
        angle <= sw_angle;
end

// mealy outputs
assign sw_swap_ready = (state == nabp_ctrl_pkg::fill_done_s);
assign sw_next_angle = (state == nabp_ctrl_pkg::init_s) ||
                       (state == nabp_ctrl_pkg::shift_done_s);
assign sh_fill_kick  = (state != nabp_ctrl_pkg::fill_s) &&
                       (next_state == nabp_ctrl_pkg::fill_s);
assign sh_shift_kick = (state != nabp_ctrl_pkg::shift_s) &&
                       (next_state == nabp_ctrl_pkg::shift_s);

always_comb
begin
    next_state = state;
    case (state)
        nabp_ctrl_pkg::init_s:
            next_state = nabp_ctrl_pkg::setup_s;
        nabp_ctrl_pkg::setup_s:
            // hold here between runs
            if (sw_angle_valid)
                next_state = nabp_ctrl_pkg::fill_s;
        nabp_ctrl_pkg::fill_s:
            if (sh_fill_done)
                next_state = nabp_ctrl_pkg::fill_done_s;
        nabp_ctrl_pkg::fill_done_s:
            if (sw_swap)
                next_state = nabp_ctrl_pkg::shift_s;
        nabp_ctrl_pkg::shift_s:
            if (sh_shift_done)
                next_state = nabp_ctrl_pkg::shift_done_s;
        nabp_ctrl_pkg::shift_done_s:
            next_state = nabp_ctrl_pkg::setup_s;
        default:
            next_state = nabp_ctrl_pkg::init_s;
    endcase
end

// shifter done pulses only arrive in the matching wait state
a_fill_done_in_fill: assert property (
    @(posedge clk) disable iff (!reset_n)
    sh_fill_done |-> (state == nabp_ctrl_pkg::fill_s)
);

a_shift_done_in_shift: assert property (
    @(posedge clk) disable iff (!reset_n)
    sh_shift_done |-> (state == nabp_ctrl_pkg::shift_s)
);

a_state_legal: assert property (
    @(posedge clk) disable iff (!reset_n)
    state inside {nabp_ctrl_pkg::init_s, nabp_ctrl_pkg::setup_s,
                  nabp_ctrl_pkg::fill_s, nabp_ctrl_pkg::fill_done_s,
                  nabp_ctrl_pkg::shift_s, nabp_ctrl_pkg::shift_done_s}
);

endmodule

// File: nabp_swap_control.sv
`timescale 1ns/100ps

module nabp_swap_control
#(
    parameter int ANGLE_W = 8
)
(
    input  logic               clk,
    input  logic               reset_n,
    // run configuration
    input  logic               run_start,
    input  logic [ANGLE_W-1:0] run_angle_start,
    input  logic [ANGLE_W:0]   run_angle_count,
    // run status
    output logic               busy,
    output logic               done,
    output logic [ANGLE_W:0]   lines_done,
    // state control handshake
    input  logic               sw_swap_ready,
    input  logic               sw_next_angle,
    output logic [ANGLE_W-1:0] sw_angle,
    output logic               sw_angle_valid,
    output logic               sw_swap
);

logic [ANGLE_W:0] count_q;
logic [ANGLE_W:0] issued;
logic [ANGLE_W:0] completed;
logic             line_complete;

// init_s also raises next_angle, only real lines count
assign line_complete  = busy && sw_next_angle && (issued > completed);
assign sw_angle_valid = busy && (issued < count_q);
assign lines_done     = completed;

always_ff @(posedge clk)
begin
    if (!reset_n)
    begin
        busy      <= 1'b0;
        done      <= 1'b0;
        sw_swap   <= 1'b0;
        sw_angle  <= '0;
        count_q   <= '0;
        issued    <= '0;
        completed <= '0;
    end
    else if (run_start)
    begin
        sw_angle  <= run_angle_start;
        count_q   <= run_angle_count;
        issued    <= '0;
        completed <= '0;
        sw_swap   <= 1'b0;
        // an empty run finishes at once
        busy      <= (run_angle_count != '0);
        done      <= (run_angle_count == '0);
    end
    else
    begin
        // one grant per ready window
        sw_swap <= busy && sw_swap_ready && !sw_swap;
        if (sw_swap)
        begin
            sw_angle <= sw_angle + 1'b1;
            issued   <= issued + 1'b1;
        end
        if (line_complete)
        begin
            completed <= completed + 1'b1;
            if (completed + 1'b1 == count_q)
            begin
                busy <= 1'b0;
                done <= 1'b1;
            end
        end
    end
end

a_swap_when_ready: assert property (
    @(posedge clk) disable iff (!reset_n)
    sw_swap |-> sw_swap_ready
);

endmodule

// File: nabp_testdata.txt
# record header: start_angle angle_count, both hex
# then angle_count rows of 16 hex samples, one projection line per row
10 2
1000 1001 1002 1003 1004 1005 1006 1007 1008 1009 100a 100b 100c 100d 100e 100f
1100 10ff 1102 10fd 1104 10fb 1106 10f9 1108 10f7 110a 10f5 110c 10f3 110e 10f1
fe 3
2a00 ffff 0000 a5a5 5a5a 2a05 2a06 2a07 8000 7fff 2a0a 2a0b 2a0c 2a0d 2a0e 2a0f
2b10 2b21 2b32 2b43 2b54 2b65 2b76 2b87 2b98 2ba9 2bba 2bcb 2bdc 2bed 2bfe 2c0f
0001 0002 0004 0008 0010 0020 0040 0080 0100 0200 0400 0800 1000 2000 4000 8000
40 1
4040 4141 4242 4343 4444 4545 4646 4747 4848 4949 4a4a 4b4b 4c4c 4d4d 4e4e 4f4f
a5 3
c3c3 3c3c 1234 5678 9abc def0 0fed cba9 8765 4321 f00f 0ff0 aaaa 5555 cccc 3333
7001 7002 7003 7004 7005 7006 7007 7008 7009 700a 700b 700c 700d 700e 700f 7010
e000 e111 e222 e333 e444 e555 e666 e777 e888 e999 eaaa ebbb eccc eddd eeee efff

// File: nabp_top.sv
`timescale 1ns/100ps

module nabp_top
#(
    parameter int ANGLE_W  = nabp_geom_pkg::ANGLE_W_DEF,
    parameter int DATA_W   = nabp_geom_pkg::DATA_W_DEF,
    parameter int LINE_LEN = nabp_geom_pkg::LINE_LEN_DEF
)
(
    input  logic               clk,
    input  logic               reset_n,
    // apb
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [3:0]         paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    // sample stream
    input  logic [DATA_W-1:0]  samp_data,
    input  logic               samp_valid,
    output logic               samp_ready,
    // line stream
    output logic [DATA_W-1:0]  line_data,
    output logic [ANGLE_W-1:0] line_angle,
    output logic               line_valid,
    output logic               line_last,
    input  logic               line_ready
);

// register block to swap control
logic               run_start;
logic [ANGLE_W-1:0] run_angle_start;
logic [ANGLE_W:0]   run_angle_count;
logic               busy;
logic               done;
logic [ANGLE_W:0]   lines_done;

// swap control to state control
logic [ANGLE_W-1:0] sw_angle;
logic               sw_angle_valid;
logic               sw_swap;
logic               sw_swap_ready;
logic               sw_next_angle;

// state control to shifter
logic               sh_fill_kick;
logic               sh_shift_kick;
logic               sh_fill_done;
logic               sh_shift_done;

nabp_apb_regs #(
    .ANGLE_W (ANGLE_W)
) u_apb_regs (
    .clk             (clk),
    .reset_n         (reset_n),
    .psel            (psel),
    .penable         (penable),
    .pwrite          (pwrite),
    .paddr           (paddr),
    .pwdata          (pwdata),
    .prdata          (prdata),
    .busy            (busy),
    .done            (done),
    .lines_done      (lines_done),
    .run_start       (run_start),
    .run_angle_start (run_angle_start),
    .run_angle_count (run_angle_count)
);

nabp_swap_control #(
    .ANGLE_W (ANGLE_W)
) u_swap_control (
    .clk             (clk),
    .reset_n         (reset_n),
    .run_start       (run_start),
    .run_angle_start (run_angle_start),
    .run_angle_count (run_angle_count),
    .busy            (busy),
    .done            (done),
    .lines_done      (lines_done),
    .sw_swap_ready   (sw_swap_ready),
    .sw_next_angle   (sw_next_angle),
    .sw_angle        (sw_angle),
    .sw_angle_valid  (sw_angle_valid),
    .sw_swap         (sw_swap)
);

// held angle tags the outgoing line
nabp_state_control #(
    .ANGLE_W (ANGLE_W)
) u_state_control (
    .clk            (clk),
    .reset_n        (reset_n),
    .sw_angle       (sw_angle),
    .sw_angle_valid (sw_angle_valid),
    .sw_swap        (sw_swap),
    .angle          (line_angle),
    .sw_swap_ready  (sw_swap_ready),
    .sw_next_angle  (sw_next_angle),
    .sh_fill_done   (sh_fill_done),
    .sh_shift_done  (sh_shift_done),
    .sh_fill_kick   (sh_fill_kick),
    .sh_shift_kick  (sh_shift_kick)
);

nabp_shifter #(
    .DATA_W   (DATA_W),
    .LINE_LEN (LINE_LEN)
) u_shifter (
    .clk           (clk),
    .reset_n       (reset_n),
    .sh_fill_kick  (sh_fill_kick),
    .sh_shift_kick (sh_shift_kick),
    .sh_fill_done  (sh_fill_done),
    .sh_shift_done (sh_shift_done),
    .samp_data     (samp_data),
    .samp_valid    (samp_valid),
    .samp_ready    (samp_ready),
    .line_data     (line_data),
    .line_valid    (line_valid),
    .line_last     (line_last),
    .line_ready    (line_ready)
);

endmodule

// File: project.f
nabp_geom_pkg.sv
nabp_ctrl_pkg.sv
nabp_apb_regs.sv
nabp_swap_control.sv
nabp_state_control.sv
nabp_shifter.sv
nabp_top.sv
tb_nabp_checker.sv
tb_nabp.sv

// File: run_sim.sh
#!/bin/sh
# build and run the nabp testbench with verilator, from the project root

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f project.f --top-module tb_nabp -o tb_nabp
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_nabp > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# pass only if the testbench printed its pass line
if grep -q "^Test OK$" "$log"; then
    exit 0
fi
echo "pass line not found in $log"
exit 1

// File: tb_nabp.sv
`timescale 1ns/100ps

module tb_nabp;

localparam int ANGLE_W    = nabp_geom_pkg::ANGLE_W_DEF;
localparam int DATA_W     = nabp_geom_pkg::DATA_W_DEF;
localparam int LINE_LEN   = nabp_geom_pkg::LINE_LEN_DEF;
localparam int CLK_PERIOD = 100;

logic               clk;
logic               reset_n;
logic               psel;
logic               penable;
logic               pwrite;
logic [3:0]         paddr;
logic [31:0]        pwdata;
logic [31:0]        prdata;
logic [DATA_W-1:0]  samp_data;
logic               samp_valid;
logic               samp_ready;
logic [DATA_W-1:0]  line_data;
logic [ANGLE_W-1:0] line_angle;
logic               line_valid;
logic               line_last;
logic               line_ready;
logic               end_of_test;
int                 stream_errors;
int                 reg_errors;

logic [DATA_W-1:0]  samples [$];
int                 rec_start [$];
int                 rec_count [$];
int                 limit_cycles = 0;
integer             seed = 32'hd9c8d4ff;

nabp_top #(
    .ANGLE_W  (ANGLE_W),
    .DATA_W   (DATA_W),
    .LINE_LEN (LINE_LEN)
) u_nabp_top (
    .clk        (clk),
    .reset_n    (reset_n),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .samp_data  (samp_data),
    .samp_valid (samp_valid),
    .samp_ready (samp_ready),
    .line_data  (line_data),
    .line_angle (line_angle),
    .line_valid (line_valid),
    .line_last  (line_last),
    .line_ready (line_ready)
);

tb_nabp_checker #(
    .ANGLE_W  (ANGLE_W),
    .DATA_W   (DATA_W),
    .LINE_LEN (LINE_LEN)
) u_checker (
    .clk           (clk),
    .reset_n       (reset_n),
    .psel          (psel),
    .penable       (penable),
    .pwrite        (pwrite),
    .paddr         (paddr),
    .pwdata        (pwdata),
    .prdata        (prdata),
    .samp_ready    (samp_ready),
    .line_data     (line_data),
    .line_angle    (line_angle),
    .line_valid    (line_valid),
    .line_last     (line_last),
    .line_ready    (line_ready),
    .end_of_test   (end_of_test),
    .stream_errors (stream_errors),
    .reg_errors    (reg_errors)
);

initial
begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

// random back-pressure on the line stream
initial
begin
    line_ready = 1'b0;
    forever
    begin
        @(posedge clk);
        #10;
        line_ready = (($random(seed) & 3) != 0);
    end
end

initial
begin
    wait (limit_cycles > 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout: run did not finish within %0d cycles", limit_cycles);
    $display("Test FAILED");
    $finish;
end

task automatic load_testdata(output bit ok);
    int fd;
    int n;
    int s;
    int c;
    int v;
    logic [8*160-1:0] text;
    ok = 1'b0;
    fd = $fopen("nabp_testdata.txt", "r");
    if (fd != 0)
    begin
        n = $fgets(text, fd);
        n = $fgets(text, fd);
        while ($fscanf(fd, "%h %h", s, c) == 2)
        begin
            rec_start.push_back(s);
            rec_count.push_back(c);
            for (int i = 0; i < c * LINE_LEN; i++)
            begin
                n = $fscanf(fd, "%h", v);
                samples.push_back(DATA_W'(v));
            end
        end
        $fclose(fd);
        ok = (rec_count.size() > 0);
    end
endtask

// bus tasks start and end 10 ns after an edge
task automatic apb_write(input logic [3:0] addr, input logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk);
    #10;
    penable = 1'b1;
    @(posedge clk);
    #10;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
endtask

task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk);
    #10;
    penable = 1'b1;
    #(CLK_PERIOD - 20);
    data = prdata;
    @(posedge clk);
    #10;
    psel    = 1'b0;
    penable = 1'b0;
endtask

task automatic send_samples(input int first, input int n);
    int  i;
    bit  taken;
    i = 0;
    while (i < n)
    begin
        samp_data  = samples[first + i];
        samp_valid = 1'b1;
        // samp_ready only changes at an edge
        taken = samp_ready;
        @(posedge clk);
        #10;
        if (taken)
            i++;
    end
    samp_valid = 1'b0;
endtask

initial
begin
    bit          ok;
    int          first;
    int          total;
    logic [31:0] rd;
    reset_n     = 1'b0;
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    samp_data   = '0;
    samp_valid  = 1'b0;
    end_of_test = 1'b0;
    load_testdata(ok);
    if (!ok)
    begin
        $display("test data file nabp_testdata.txt could not be read");
        $display("Test FAILED");
        $finish;
    end
    else
    begin
        total = 0;
        foreach (rec_count[r])
            total += rec_count[r] * (2 * LINE_LEN + 10) * 4;
        limit_cycles = total + 200;
        repeat (5) @(posedge clk);
        #10;
        reset_n = 1'b1;
        @(posedge clk);
        #10;
        apb_read(nabp_ctrl_pkg::REG_STATUS, rd);
        first = 0;
        foreach (rec_count[r])
        begin
            apb_write(nabp_ctrl_pkg::REG_ANGLE_START, rec_start[r]);
            apb_write(nabp_ctrl_pkg::REG_ANGLE_COUNT, rec_count[r]);
            apb_read(nabp_ctrl_pkg::REG_ANGLE_START, rd);
            apb_read(nabp_ctrl_pkg::REG_ANGLE_COUNT, rd);
            apb_write(nabp_ctrl_pkg::REG_CTRL, 32'h1 << nabp_ctrl_pkg::CTRL_START_BIT);
            apb_read(nabp_ctrl_pkg::REG_STATUS, rd);
            send_samples(first, rec_count[r] * LINE_LEN);
            first += rec_count[r] * LINE_LEN;
            // the last line is still shifting, a restart here would hang the run
            apb_write(nabp_ctrl_pkg::REG_CTRL, 32'h1 << nabp_ctrl_pkg::CTRL_START_BIT);
            rd = '0;
            while (!rd[nabp_ctrl_pkg::STATUS_DONE_BIT])
                apb_read(nabp_ctrl_pkg::REG_STATUS, rd);
        end
        end_of_test = 1'b1;
        repeat (2) @(posedge clk);
        $display("errors: line stream %0d, registers %0d", stream_errors, reg_errors);
        if (stream_errors == 0 && reg_errors == 0)
            $display("Test OK");
        else
            $display("Test FAILED");
        $finish;
    end
end

endmodule

// File: tb_nabp_checker.sv
`timescale 1ns/100ps

module tb_nabp_checker
#(
    parameter int ANGLE_W  = 8,
    parameter int DATA_W   = 16,
    parameter int LINE_LEN = 16
)
(
    input  logic               clk,
    input  logic               reset_n,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [3:0]         paddr,
    input  logic [31:0]        pwdata,
    input  logic [31:0]        prdata,
    input  logic               samp_ready,
    input  logic [DATA_W-1:0]  line_data,
    input  logic [ANGLE_W-1:0] line_angle,
    input  logic               line_valid,
    input  logic               line_last,
    input  logic               line_ready,
    input  logic               end_of_test,
    output int                 stream_errors,
    output int                 reg_errors
);

logic [DATA_W-1:0]  exp_samp [$];
int                 rec_start [$];
int                 rec_count [$];
int                 xfer_idx;
int                 pos_in_line;
int                 line_in_rec;
int                 rec_idx;
int                 run_lines;
int                 run_count;
logic [ANGLE_W-1:0] wr_start;
logic [ANGLE_W:0]   wr_count;
logic [ANGLE_W-1:0] exp_angle;
logic [31:0]        exp_status;
logic [DATA_W-1:0]  held_data;
bit                 stalled;
bit                 run_active;
bit                 ever_started;
bit                 first_status;
bit                 reset_checked;
bit                 final_checked;

// same records the testbench drives
initial
begin
    int fd;
    int n;
    int s;
    int c;
    int v;
    logic [8*160-1:0] text;
    fd = $fopen("nabp_testdata.txt", "r");
    if (fd == 0)
    begin
        $display("checker could not open nabp_testdata.txt");
    end
    else
    begin
        n = $fgets(text, fd);
        n = $fgets(text, fd);
        while ($fscanf(fd, "%h %h", s, c) == 2)
        begin
            rec_start.push_back(s);
            rec_count.push_back(c);
            for (int i = 0; i < c * LINE_LEN; i++)
            begin
                n = $fscanf(fd, "%h", v);
                exp_samp.push_back(DATA_W'(v));
            end
        end
        $fclose(fd);
    end
end

task automatic compare_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual, input bit on_bus);
    if (actual !== expected)
    begin
        $display("FAILED at %0t: %s expected %0h got %0h", $time, name, expected, actual);
        if (on_bus)
            reg_errors++;
        else
            stream_errors++;
    end
endtask

task automatic check_transfer();
    if (xfer_idx >= exp_samp.size())
    begin
        $display("extra line transfer at %0t beyond the test data", $time);
        stream_errors++;
    end
    else
    begin
        // line k of a record carries start + k, wrapping
        exp_angle = ANGLE_W'(rec_start[rec_idx] + line_in_rec);
        compare_value("line_data", 32'(exp_samp[xfer_idx]), 32'(line_data), 1'b0);
        compare_value("line_angle", 32'(exp_angle), 32'(line_angle), 1'b0);
        compare_value("line_last", 32'(pos_in_line == LINE_LEN - 1), 32'(line_last), 1'b0);
        xfer_idx++;
        pos_in_line++;
        if (pos_in_line == LINE_LEN)
        begin
            pos_in_line = 0;
            line_in_rec++;
            run_lines++;
            if (line_in_rec == rec_count[rec_idx])
            begin
                rec_idx++;
                line_in_rec = 0;
            end
        end
    end
endtask

task automatic check_status();
    exp_status = 32'(run_count) << nabp_ctrl_pkg::STATUS_LINES_LSB;
    exp_status[nabp_ctrl_pkg::STATUS_DONE_BIT] = 1'b1;
    if (!ever_started)
        compare_value("status after reset", 32'h0, prdata, 1'b1);
    else if (!run_active)
        compare_value("status after run", exp_status, prdata, 1'b1);
    else if (first_status)
    begin
        // a new start clears done and the line count
        exp_status = 32'h0;
        exp_status[nabp_ctrl_pkg::STATUS_BUSY_BIT] = 1'b1;
        compare_value("status at start", exp_status, prdata, 1'b1);
        first_status = 1'b0;
    end
    else if (prdata[nabp_ctrl_pkg::STATUS_DONE_BIT])
    begin
        compare_value("status at done", exp_status, prdata, 1'b1);
        compare_value("lines seen in run", 32'(run_count), 32'(run_lines), 1'b1);
        run_active = 1'b0;
    end
    else
        compare_value("status busy", 32'h1,
                      32'(prdata[nabp_ctrl_pkg::STATUS_BUSY_BIT]), 1'b1);
endtask

task automatic watch_apb();
    if (pwrite)
    begin
        if (paddr == nabp_ctrl_pkg::REG_ANGLE_START)
            wr_start = pwdata[ANGLE_W-1:0];
        else if (paddr == nabp_ctrl_pkg::REG_ANGLE_COUNT)
            wr_count = pwdata[ANGLE_W:0];
        else if (paddr == nabp_ctrl_pkg::REG_CTRL &&
                 pwdata[nabp_ctrl_pkg::CTRL_START_BIT] && !run_active)
        begin
            // starts during a run are ignored by the DUT
            run_active   = 1'b1;
            ever_started = 1'b1;
            first_status = 1'b1;
            run_count    = int'(wr_count);
            run_lines    = 0;
        end
    end
    else if (paddr == nabp_ctrl_pkg::REG_ANGLE_START)
        compare_value("angle_start readback", 32'(wr_start), prdata, 1'b1);
    else if (paddr == nabp_ctrl_pkg::REG_ANGLE_COUNT)
        compare_value("angle_count readback", 32'(wr_count), prdata, 1'b1);
    else if (paddr == nabp_ctrl_pkg::REG_STATUS)
        check_status();
endtask

always @(posedge clk)
begin
    if (!reset_n)
    begin
        stream_errors = 0;
        reg_errors    = 0;
        xfer_idx      = 0;
        pos_in_line   = 0;
        line_in_rec   = 0;
        rec_idx       = 0;
        run_lines     = 0;
        run_count     = 0;
        wr_start      = '0;
        wr_count      = '0;
        stalled       = 1'b0;
        run_active    = 1'b0;
        ever_started  = 1'b0;
        first_status  = 1'b0;
        reset_checked = 1'b0;
        final_checked = 1'b0;
    end
    else
    begin
        if (!reset_checked)
        begin
            compare_value("samp_ready after reset", 32'h0, 32'(samp_ready), 1'b0);
            compare_value("line_valid after reset", 32'h0, 32'(line_valid), 1'b0);
            compare_value("line_last after reset", 32'h0, 32'(line_last), 1'b0);
            reset_checked = 1'b1;
        end
        // stalled beat must hold until taken
        if (stalled)
        begin
            if (!line_valid)
            begin
                $display("line_valid dropped at %0t while line_ready was low", $time);
                stream_errors++;
            end
            else
                compare_value("line_data held", 32'(held_data), 32'(line_data), 1'b0);
        end
        stalled   = line_valid && !line_ready;
        held_data = line_data;
        if (line_valid && line_ready)
            check_transfer();
        if (psel && penable)
            watch_apb();
        if (end_of_test && !final_checked)
        begin
            compare_value("line transfers", 32'(exp_samp.size()), 32'(xfer_idx), 1'b0);
            final_checked = 1'b1;
        end
    end
end

endmodule
